// File: filelist.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_regs.sv
hdl/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv_core \
    --Mdir obj_dir \
    -f filelist.f

./obj_dir/Vtb_rv_core

// File: test/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    import rv_pkg::*;

    localparam logic [XLEN-1:0] RESET_ADDR   = 32'h0000_1000;
    localparam int              NUM_INSTR    = 400;
    localparam int              TIMEOUT      = NUM_INSTR * 3 + 50; // Worst gap is 3 cycles.
    localparam int              RESET_CYCLES = 10;

    typedef struct packed
    {
        int          due;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_req;
    logic [XLEN-1:0]       instr_addr;
    logic                  instr_ack;
    logic [XLEN-1:0]       instr_data;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  illegal;

    logic [31:0] model_regs [0:31];
    wb_exp_t     wb_q [$];  // Expected write-backs in retire order.
    int          ill_q [$]; // Due cycles of illegal pulses.
    logic [31:0] rng;
    logic [31:0] exp_addr;
    int          cyc;
    int          issued;
    int          gap;

    tb_clock clock_i
    (
        .o_clk          (clk)
    );

    rv_core
    #(
        .RESET_ADDR     (RESET_ADDR)
    )
    rv_core_i
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .i_instr_ack    (instr_ack),
        .i_instr_data   (instr_data),
        .o_wb_valid     (wb_valid),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data),
        .o_illegal      (illegal)
    );

    // ####################
    // Stimulus
    // ####################

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Registers come from x0 to x7 so that neighbours often depend on each other.
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = draw();
        rd  = {2'b00, r[6:4]};
        rs1 = {2'b00, r[9:7]};
        rs2 = {2'b00, r[12:10]};
        f3  = r[15:13];
        f7  = (r[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        case (r[3:0])
            4'd0:       return {r[31:7], r[22:17], 1'b0}; // No legal opcode has bit 0 clear.
            4'd1, 4'd2: return {r[31:12], rd, OPC_LUI};
            4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8:
                return {f7, rs2, rs1, f3, rd, OPC_OP};
            default:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)
                begin
                    return {f7, r[21:17], rs1, f3, rd, OPC_OP_IMM}; // Shift amount.
                end
                return {r[31:20], rs1, f3, rd, OPC_OP_IMM};
            end
        endcase
    endfunction

    // ####################
    // Reference model
    // ####################

    task automatic model_step(input logic [31:0] word, input int ack_cyc);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sra;
        logic [31:0] res;
        logic        ok;
        logic        f7_used;
        wb_exp_t     e;
        opc = word[6:0];
        rd  = word[11:7];
        f3  = word[14:12];
        f7  = word[31:25];
        a   = model_regs[word[19:15]];
        b   = (opc == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sra = $signed(a) >>> b[4:0];
        ok  = 1'b1;
        res = '0;
        f7_used = opc == OPC_OP || f3 == 3'b001 || f3 == 3'b101;
        if (opc == OPC_LUI)
        begin
            res = {word[31:12], 12'h000};
        end
        else if (opc == OPC_OP || opc == OPC_OP_IMM)
        begin
            // Only SUB and SRA take funct7 0100000, and OP-IMM has no SUB.
            if (f7_used && f7 != 7'h00 &&
                !(f7 == 7'h20 && (f3 == 3'b101 || (f3 == 3'b000 && opc == OPC_OP))))
            begin
                ok = 1'b0;
            end
            case (f3)
                3'b000:  res = (opc == OPC_OP && f7 == 7'h20) ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                3'b011:  res = {31'b0, a < b};
                3'b100:  res = a ^ b;
                3'b101:  res = (f7 == 7'h20) ? sra : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        else
        begin
            ok = 1'b0;
        end
        if (!ok)
        begin
            ill_q.push_back(ack_cyc + 2);
        end
        else if (rd != 5'd0)
        begin
            model_regs[rd] = res;
            e.due  = ack_cyc + 3;
            e.rd   = rd;
            e.data = res;
            wb_q.push_back(e);
        end
    endtask

    // ####################
    // Checks
    // ####################

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s: got 0x%08h, expected 0x%08h, cycle %0d", name, got, exp, cyc);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s, cycle %0d", what, cyc);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_outputs();
        wb_exp_t e;
        logic    wb_due;
        logic    ill_due;
        wb_due  = wb_q.size() > 0 && wb_q[0].due == cyc;
        ill_due = ill_q.size() > 0 && ill_q[0] == cyc;
        assert (wb_valid == wb_due)
        else report_value("o_wb_valid", 32'(wb_valid), 32'(wb_due));
        if (wb_due)
        begin
            e = wb_q.pop_front();
            assert (wb_rd == e.rd)
            else report_value("o_wb_rd", 32'(wb_rd), 32'(e.rd));
            assert (wb_data == e.data)
            else report_value("o_wb_data", wb_data, e.data);
        end
        assert (illegal == ill_due)
        else report_value("o_illegal", 32'(illegal), 32'(ill_due));
        if (ill_due)
        begin
            void'(ill_q.pop_front());
        end
        assert (instr_req == 1'b1)
        else report_value("o_instr_req", 32'(instr_req), 32'h1);
        assert (instr_addr == exp_addr) // Also holds while the ack is pending.
        else report_value("o_instr_addr", instr_addr, exp_addr);
    endtask

    // Output checks of one clock cycle followed by the instruction memory response.
    task automatic step_cycle(input logic allow_ack);
        logic [31:0] word;
        @(posedge clk);
        #1;
        cyc = cyc + 1;
        if (cyc > TIMEOUT)
        begin
            report_error("the run did not finish within the cycle limit");
        end
        check_outputs();
        instr_ack  = 1'b0;
        instr_data = '0;
        if (allow_ack && instr_req)
        begin
            if (gap == 0)
            begin
                word       = random_instr();
                instr_ack  = 1'b1;
                instr_data = word;
                model_step(word, cyc);
                exp_addr   = exp_addr + 32'd4;
                issued     = issued + 1;
                gap        = int'(draw() % 32'd3); // Wait 0 to 2 cycles.
            end
            else
            begin
                gap = gap - 1;
            end
        end
    endtask

    initial
    begin
        rst_n      = 1'b0;
        instr_ack  = 1'b0;
        instr_data = '0;
        rng        = 32'h3a59;
        exp_addr   = RESET_ADDR;
        cyc        = 0;
        issued     = 0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        gap = int'(draw() % 32'd3);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (issued < NUM_INSTR || wb_q.size() != 0 || ill_q.size() != 0)
        begin
            step_cycle(issued < NUM_INSTR);
        end
        repeat (4)
        begin
            step_cycle(1'b0); // Pipeline stays quiet once drained.
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
    output logic o_clk
);

    localparam time HALF_PERIOD = 2ns; // 4 ns period.

    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core
#(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    output logic                          o_instr_req,
    output logic [rv_pkg::XLEN-1:0]       o_instr_addr,
    input  logic                          i_instr_ack,
    input  logic [rv_pkg::XLEN-1:0]       i_instr_data,
    output logic                          o_wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data,
    output logic                          o_illegal
);

    import rv_pkg::*;

    logic                  f_valid;
    logic [XLEN-1:0]       f_instr;

    logic                  d_valid;
    alu_op_t               d_alu_op;
    logic [REG_ADDR_W-1:0] d_rd;
    logic [XLEN-1:0]       d_op1;
    logic [XLEN-1:0]       d_op2;

    logic                  e_valid;
    logic [REG_ADDR_W-1:0] e_rd;
    logic [XLEN-1:0]       e_result;

    logic                  x_valid;
    logic [REG_ADDR_W-1:0] x_rd;
    logic [XLEN-1:0]       x_result;

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    rv_fetch
    #(
        .RESET_ADDR     (RESET_ADDR)
    )
    u_fetch
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_valid        (f_valid),
        .o_instr        (f_instr)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (f_valid),
        .i_instr        (f_instr),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_fwd_valid    (e_valid),
        .i_fwd_rd       (e_rd),
        .i_fwd_data     (e_result),
        .o_valid        (d_valid),
        .o_alu_op       (d_alu_op),
        .o_rd           (d_rd),
        .o_op1          (d_op1),
        .o_op2          (d_op2),
        .o_illegal      (o_illegal)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (d_valid),
        .i_alu_op       (d_alu_op),
        .i_rd           (d_rd),
        .i_op1          (d_op1),
        .i_op2          (d_op2),
        .o_fwd_valid    (e_valid),
        .o_fwd_rd       (e_rd),
        .o_fwd_result   (e_result),
        .o_valid        (x_valid),
        .o_rd           (x_rd),
        .o_result       (x_result)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .i_wr_valid     (x_valid),
        .i_wr_rd        (x_rd),
        .i_wr_data      (x_result),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data)
    );

endmodule

// File: hdl/rv_regs.sv
`timescale 1ns/1ps

module rv_regs
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data,
    input  logic                          i_wr_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wr_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wr_data,
    output logic                          o_wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 is not stored.

    // Reads see a write of the same cycle.
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] rs);
        if (rs == '0)
        begin
            return '0;
        end
        if (i_wr_valid && i_wr_rd == rs)
        begin
            return i_wr_data;
        end
        return regs[rs];
    endfunction

    always_comb
    begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

    always_ff @(posedge i_clk)
    begin
        if (i_wr_valid && i_wr_rd != '0)
        begin
            regs[i_wr_rd] <= i_wr_data;
        end
    end

    assign o_wb_valid = i_wr_valid;
    assign o_wb_rd    = i_wr_rd;
    assign o_wb_data  = i_wr_data;

    // Decode drops rd zero before execute.
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_valid |-> i_wr_rd != '0);

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_valid,
    input  rv_pkg::alu_op_t               i_alu_op,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_op1,
    input  logic [rv_pkg::XLEN-1:0]       i_op2,
    output logic                          o_fwd_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_fwd_rd,
    output logic [rv_pkg::XLEN-1:0]       o_fwd_result,
    output logic                          o_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_pkg::XLEN-1:0]       o_result
);

    import rv_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_result;

    assign shamt = i_op2[4:0];

    // ####################
    // ALU
    // ####################

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:  alu_result = i_op1 + i_op2;
            ALU_SUB:  alu_result = i_op1 - i_op2;
            ALU_SLL:  alu_result = i_op1 << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(i_op1) < $signed(i_op2)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, i_op1 < i_op2};
            ALU_XOR:  alu_result = i_op1 ^ i_op2;
            ALU_SRL:  alu_result = i_op1 >> shamt;
            ALU_SRA:  alu_result = $signed(i_op1) >>> shamt;
            ALU_OR:   alu_result = i_op1 | i_op2;
            ALU_AND:  alu_result = i_op1 & i_op2;
            ALU_PASS: alu_result = i_op2; // LUI.
            default:  alu_result = '0;
        endcase
    end

    // Result of the instruction in this stage, back to decode.
    assign o_fwd_valid  = i_valid;
    assign o_fwd_rd     = i_rd;
    assign o_fwd_result = alu_result;

    // ####################
    // Result register
    // ####################

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rd     <= i_rd;
        o_result <= alu_result;
    end

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_valid,
    input  logic [rv_pkg::XLEN-1:0]       i_instr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic                          i_fwd_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_fwd_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_fwd_data,
    output logic                          o_valid,
    output rv_pkg::alu_op_t               o_alu_op,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_pkg::XLEN-1:0]       o_op1,
    output logic [rv_pkg::XLEN-1:0]       o_op2,
    output logic                          o_illegal
);

    import rv_pkg::*;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // SUB and SRA.

    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  alt;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       op2;
    alu_op_t               alu_op;
    logic                  legal;

    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic use_alt);
        case (f3)
            3'b000:  return use_alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return use_alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Take the execute result when it targets this source register.
    function automatic logic [XLEN-1:0] fwd_select(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       reg_data,
        input logic                  fwd_valid,
        input logic [REG_ADDR_W-1:0] fwd_rd,
        input logic [XLEN-1:0]       fwd_data
    );
        if (fwd_valid && fwd_rd == rs && rs != '0)
        begin
            return fwd_data;
        end
        return reg_data;
    endfunction

    // ####################
    // Fields
    // ####################

    assign opcode = opcode_t'(i_instr[6:0]);
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign funct7 = i_instr[31:25];
    assign alt    = funct7 == FUNCT7_ALT;

    assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};

    assign rs1_val = fwd_select(o_rs1, i_rs1_data, i_fwd_valid, i_fwd_rd, i_fwd_data);
    assign rs2_val = fwd_select(o_rs2, i_rs2_data, i_fwd_valid, i_fwd_rd, i_fwd_data);

    // ####################
    // Decode
    // ####################

    always_comb
    begin
        legal  = 1'b0;
        alu_op = ALU_ADD;
        op2    = rs2_val;
        case (opcode)
            OPC_OP:
            begin
                legal  = funct7 == FUNCT7_BASE ||
                         (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                alu_op = funct_to_alu(funct3, alt);
            end
            OPC_OP_IMM:
            begin
                case (funct3)
                    3'b001:  legal = funct7 == FUNCT7_BASE;
                    3'b101:  legal = funct7 == FUNCT7_BASE || alt;
                    default: legal = 1'b1;
                endcase
                alu_op = funct_to_alu(funct3, funct3 == 3'b101 && alt); // No SUBI.
                op2    = imm_i;
            end
            OPC_LUI:
            begin
                legal  = 1'b1;
                alu_op = ALU_PASS;
                op2    = imm_u;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
        end
        else
        begin
            o_valid   <= i_valid & legal & (rd != '0); // Writes to x0 are dropped here.
            o_illegal <= i_valid & ~legal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_alu_op <= alu_op;
        o_rd     <= rd;
        o_op1    <= rs1_val;
        o_op2    <= op2;
    end

    a_valid_or_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_valid && o_illegal));

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
#(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    output logic                    o_instr_req,
    output logic [rv_pkg::XLEN-1:0] o_instr_addr,
    input  logic                    i_instr_ack,
    input  logic [rv_pkg::XLEN-1:0] i_instr_data,
    output logic                    o_valid,
    output logic [rv_pkg::XLEN-1:0] o_instr
);

    import rv_pkg::*;

    logic accept;

    assign accept = o_instr_req & i_instr_ack; // Word taken this cycle.

    // Request level, program counter and fetch valid.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_instr_req  <= 1'b0;
            o_instr_addr <= RESET_ADDR;
            o_valid      <= 1'b0;
        end
        else
        begin
            o_instr_req <= 1'b1;
            if (accept)
            begin
                o_instr_addr <= o_instr_addr + XLEN'(4);
            end
            o_valid <= accept;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            o_instr <= i_instr_data;
        end
    end

    // The address waits for its ack.
    a_addr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_instr_req && !i_instr_ack) |=> $stable(o_instr_addr));

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    // ####################
    // Widths
    // ####################

    parameter int XLEN       = 32; // Data and address width.
    parameter int REG_ADDR_W = 5;  // Register index width.

    // ####################
    // Opcodes
    // ####################

    // Major opcode field, bits 6:0 of the instruction word.
    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011, // Register-register.
        OPC_OP_IMM = 7'b0010011, // Register-immediate.
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // ####################
    // ALU operations
    // ####################

    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_PASS = 4'd10 // Operand 2 unchanged.
    } alu_op_t;

endpackage
